/* run.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJDIR=obj_dir

verilator --binary --timescale 1ns/10ps \
	-f verilog.f \
	--top-module tb_shiftAddMultiplier \
	-Mdir "$OBJDIR" -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJDIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q -x "PASS: all tests" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

/* test/mul_stim.txt */
# a        b        expected product
# Unsigned 32-bit operands and 64-bit product, all in hexadecimal
00000000 00000000 0000000000000000
00000000 ffffffff 0000000000000000
ffffffff 00000000 0000000000000000
00000001 00000001 0000000000000001
00000001 ffffffff 00000000ffffffff
ffffffff 00000001 00000000ffffffff
ffffffff ffffffff fffffffe00000001
80000000 80000000 4000000000000000
80000000 00000002 0000000100000000
00000002 80000000 0000000100000000
00010000 00010000 0000000100000000
00001000 00100000 0000000100000000
00000001 80000000 0000000080000000
c0000000 00000004 0000000300000000
ffffffff 00000002 00000001fffffffe
ffffffff 80000000 7fffffff80000000
ffffffff 00000010 0000000ffffffff0
7fffffff 00000002 00000000fffffffe
7fffffff 7fffffff 3fffffff00000001
fffffffe 00000002 00000001fffffffc
aaaaaaaa 00000003 00000001fffffffe
55555555 00000003 00000000ffffffff
0000ffff 0000ffff 00000000fffe0001
ffff0000 0000ffff 0000fffe00010000
000000ff 000000ff 000000000000fe01
00ffffff 00000100 00000000ffffff00
f0000000 00000010 0000000f00000000
12345678 00000001 0000000012345678
12345678 00000010 0000000123456780
12345678 00000000 0000000000000000
deadbeef 00000000 0000000000000000
deadbeef 00000002 00000001bd5b7dde
00000003 00000005 000000000000000f
00000005 00000005 0000000000000019
00000007 00000009 000000000000003f
0000000a 0000000a 0000000000000064
00000011 00000011 0000000000000121
00000064 00000064 0000000000002710
000003e8 000003e8 00000000000f4240
0001ffff 00000002 000000000003fffe

/* test/tb_shiftAddMultiplier.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mulConfig_config.svh"

// Self-checking testbench of the shift-and-add multiplier
// Operands and expected products come from the stimulus file
// Inputs change 1 ns after each rising edge, outputs are read at the same point
module tb_shiftAddMultiplier import mulTypes_pkg::*;
();

	// Edges from the accepting edge up to done rising
	localparam int Latency = `MUL_WIDTH + 1;

	// Upper bound on the wait for done
	localparam int DoneTimeout = 4 * `MUL_WIDTH;

	logic     Clock;
	logic     Reset;
	logic     validData;
	logic     ack;
	operand_t a;
	operand_t b;
	product_t product;
	logic     done;

	// Test cases read from the stimulus file
	operand_t caseA[$];
	operand_t caseB[$];
	product_t caseProduct[$];

	// Random source for ack delays and busy pulses
	logic [31:0] lfsrState;

	shiftAddMultiplier shiftAddMultiplier_i
	(
		.Clock     (Clock),
		.Reset     (Reset),
		.validData (validData),
		.ack       (ack),
		.a         (a),
		.b         (b),
		.product   (product),
		.done      (done)
	);

	// 20 ns clock
	initial
	begin
		Clock = 1'b0;
		forever
		begin
			#10 Clock = ~Clock;
		end
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken, newest bit in the lsb
	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkProduct(input string name, input product_t expected,
		input product_t actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkDone(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %b actual %b", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("Error: %s expected %0d actual %0d", name, expected, actual);
			abortRun();
		end
	endtask

	// Step to the drive and sample point of the next cycle
	task automatic nextCycle();
		@(posedge Clock);
		#1;
	endtask

	// Coin flip: request with random operands, or no request
	task automatic driveBusyPulse();
		logic [31:0] coin;
		logic [31:0] randA;
		logic [31:0] randB;
		drawBits(1, coin);
		if (coin[0])
		begin
			drawBits(32, randA);
			drawBits(32, randB);
			a = randA;
			b = randB;
			validData = 1'b1;
		end
		else
		begin
			validData = 1'b0;
		end
	endtask

	// Lines starting with # are comments
	task automatic readStimulus();
		int fd;
		int fields;
		string line;
		operand_t fileA;
		operand_t fileB;
		product_t fileProduct;
		fd = $fopen("test/mul_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file test/mul_stim.txt");
			abortRun();
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != 8'h0a)
				begin
					fields = $sscanf(line, "%h %h %h", fileA, fileB, fileProduct);
					if (fields != 3)
					begin
						$display("Malformed line in the stimulus file: %s", line);
						abortRun();
					end
					else
					begin
						caseA.push_back(fileA);
						caseB.push_back(fileB);
						caseProduct.push_back(fileProduct);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One multiplication from request in Idle to release by ack
	task automatic runCase(input int index);
		int cycles;
		int holdCycles;
		logic [31:0] delayBits;
		string name;
		name = $sformatf("case %0d", index);
		a = caseA[index];
		b = caseB[index];
		validData = 1'b1;
		ack = 1'b0;
		// This edge takes the operands in and is the first edge counted
		nextCycle();
		cycles = 1;
		driveBusyPulse();
		while (done !== 1'b1)
		begin
			if (cycles >= DoneTimeout)
			begin
				$display("Timeout: done never rose in %s within %0d cycles", name, cycles);
				abortRun();
			end
			else
			begin
				nextCycle();
				cycles++;
				// Requests while busy must be ignored
				driveBusyPulse();
			end
		end
		checkCycles({name, " latency"}, Latency, cycles);
		checkProduct({name, " product"}, caseProduct[index], product);
		// Ack withheld for 0 to 7 cycles
		drawBits(3, delayBits);
		holdCycles = int'(delayBits);
		for (int i = 0; i < holdCycles; i++)
		begin
			nextCycle();
			driveBusyPulse();
			checkDone({name, " hold done"}, 1'b1, done);
			checkProduct({name, " hold product"}, caseProduct[index], product);
		end
		validData = 1'b0;
		ack = 1'b1;
		// done falls on the edge that samples ack
		nextCycle();
		checkDone({name, " release done"}, 1'b0, done);
		ack = 1'b0;
	endtask

	initial
	begin
		Reset = 1'b1;
		validData = 1'b0;
		ack = 1'b0;
		a = '0;
		b = '0;
		lfsrState = 32'h13522cf9;
		readStimulus();
		if (caseA.size() == 0)
		begin
			$display("The stimulus file holds no test cases");
			abortRun();
		end
		// Reset over two rising edges
		repeat (2) @(posedge Clock);
		#1;
		Reset = 1'b0;
		checkDone("reset done", 1'b0, done);
		checkProduct("reset product", '0, product);
		// Nothing moves without a request
		for (int i = 0; i < 4; i++)
		begin
			nextCycle();
			checkDone("idle done", 1'b0, done);
			checkProduct("idle product", '0, product);
		end
		for (int i = 0; i < caseA.size(); i++)
		begin
			runCase(i);
		end
		nextCycle();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/mulTypes_pkg.sv
verilog/mulController.sv
verilog/mulDatapath.sv
verilog/shiftAddMultiplier.sv
test/tb_shiftAddMultiplier.sv

/* verilog/mulConfig_config.svh */
`ifndef MUL_CONFIG_CONFIG_SVH
`define MUL_CONFIG_CONFIG_SVH

// Width of each operand in bits
// The datapath and the controller do not depend on this value being 32
`define MUL_WIDTH 32

// Full product of two operands needs twice the operand width
`define MUL_PRODUCT_WIDTH (2 * `MUL_WIDTH)

// Bit counter width
// Must hold values from 0 up to MUL_WIDTH
`define MUL_COUNT_WIDTH 6

`endif

/* verilog/mulController.sv */
`timescale 1ns/10ps
`default_nettype none

// Sequencer of the shift-and-add multiplier
// Moore machine with three states
// Load and step go to the datapath, done goes out of the unit
module mulController import mulTypes_pkg::*;
(
	input  wire logic Clock,
	input  wire logic Reset,

	// Request and release from the outside
	input  wire logic validData,
	input  wire logic ack,

	// Status from the datapath
	input  wire logic lastStep,

	// Commands to the datapath
	output logic      load,
	output logic      step,

	// Result valid flag
	output logic      done
);

	// Present and next state
	mulState_t currentState;
	mulState_t nextState;

	// Value that done takes on the next edge
	logic nextDone;

	// State register and registered output
	// Both are cleared to the idle condition by Reset
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			currentState <= Idle;
			done         <= 1'b0;
		end
		else
		begin
			currentState <= nextState;
			done         <= nextDone;
		end
	end

	// Next state logic
	always_comb
	begin
		// Stay put unless a transition condition is met
		nextState = currentState;

		case (currentState)
			Idle:
			begin
				// A new multiplication starts only from here
				if (validData)
				begin
					nextState = Calc;
				end
			end

			Calc:
			begin
				// One multiplier bit per clock
				// validData is ignored while busy
				if (lastStep)
				begin
					nextState = Done;
				end
			end

			Done:
			begin
				// Result is held until the consumer acknowledges it
				if (ack)
				begin
					nextState = Idle;
				end
			end

			default:
			begin
				// Recover from an illegal encoding
				nextState = Idle;
			end
		endcase
	end

	// done follows the state it will be in after the edge
	// so that it is high exactly while the state is Done
	always_comb
	begin
		nextDone = (nextState == Done);
	end

	// Datapath commands decoded from the present state
	always_comb
	begin
		load = 1'b0;
		step = 1'b0;

		case (currentState)
			Idle:
			begin
				// Operands are taken in on the accepting edge
				load = validData;
			end

			Calc:
			begin
				// Every Calc cycle processes one bit
				step = 1'b1;
			end

			default:
			begin
				// Done holds everything still
				load = 1'b0;
				step = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/mulDatapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mulConfig_config.svh"

// Datapath of the shift-and-add multiplier
// Multiplicand shifts left, multiplier shifts right
// Product accumulates the multiplicand for each multiplier bit that is set
module mulDatapath import mulTypes_pkg::*;
(
	input  wire logic     Clock,
	input  wire logic     Reset,

	// Operands, sampled on load
	input  wire operand_t a,
	input  wire operand_t b,

	// Commands from the controller
	input  wire logic     load,
	input  wire logic     step,

	// Accumulated product
	output product_t      product,

	// High during the step that handles the last multiplier bit
	output logic          lastStep
);

	// Counter value seen during the final step
	localparam count_t LastCount = count_t'(`MUL_WIDTH - 1);

	// Multiplicand widened to the product width so it can shift left freely
	product_t multiplicand;

	// Multiplier shifts right, its lsb selects the add
	operand_t multiplier;

	// Running sum of partial products
	product_t accumulator;

	// Number of multiplier bits already processed
	count_t bitCount;

	// Accumulator plus the current partial product
	product_t partialSum;

	// Partial product is either the shifted multiplicand or zero
	always_comb
	begin
		if (multiplier[0])
		begin
			partialSum = accumulator + multiplicand;
		end
		else
		begin
			partialSum = accumulator;
		end
	end

	// Operand shift registers
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			multiplicand <= '0;
			multiplier   <= '0;
		end
		else if (load)
		begin
			// Upper half of the multiplicand starts at zero
			multiplicand <= product_t'(a);
			multiplier   <= b;
		end
		else if (step)
		begin
			// Next bit weight
			multiplicand <= multiplicand << 1;
			multiplier   <= multiplier >> 1;
		end
	end

	// Product accumulator
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			accumulator <= '0;
		end
		else if (load)
		begin
			// Fresh sum for every new pair of operands
			accumulator <= '0;
		end
		else if (step)
		begin
			accumulator <= partialSum;
		end
	end

	// Bit counter
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			bitCount <= '0;
		end
		else if (load)
		begin
			bitCount <= '0;
		end
		else if (step)
		begin
			bitCount <= bitCount + count_t'(1);
		end
	end

	// Controller leaves Calc on the edge that ends this step
	always_comb
	begin
		lastStep = (bitCount == LastCount);
	end

	// Result is read straight from the accumulator
	// It stays unchanged after the last step since no step follows
	always_comb
	begin
		product = accumulator;
	end

endmodule

`default_nettype wire

/* verilog/mulTypes_pkg.sv */
`default_nettype none

`include "mulConfig_config.svh"

package mulTypes_pkg;

	// Multiplier or multiplicand value as presented at the inputs
	typedef logic [`MUL_WIDTH-1:0] operand_t;

	// Accumulated partial product and final result
	typedef logic [`MUL_PRODUCT_WIDTH-1:0] product_t;

	// Number of multiplier bits already processed
	typedef logic [`MUL_COUNT_WIDTH-1:0] count_t;

	// Controller states
	// Idle waits for validData
	// Calc runs one shift-add step per clock
	// Done holds the result until ack
	typedef enum logic [1:0]
	{
		Idle = 2'd0,
		Calc = 2'd1,
		Done = 2'd2
	} mulState_t;

endpackage

`default_nettype wire

/* verilog/shiftAddMultiplier.sv */
`timescale 1ns/10ps
`default_nettype none

// Iterative 32 by 32 unsigned multiplier
// One multiplication in flight at a time
// validData starts it, done flags the result, ack releases it
module shiftAddMultiplier import mulTypes_pkg::*;
(
	input  wire logic     Clock,
	input  wire logic     Reset,

	// Start request, sampled only while idle
	input  wire logic     validData,

	// Result release, sampled only while done is high
	input  wire logic     ack,

	// Operands
	input  wire operand_t a,
	input  wire operand_t b,

	// Result, valid while done is high
	output product_t      product,
	output logic          done
);

	// Copy operands, clear product and counter
	logic load;

	// One shift-add iteration
	logic step;

	// Final bit is being processed
	logic lastStep;

	// Sequencing of load, steps and result hold
	mulController mulController_i
	(
		.Clock     (Clock),
		.Reset     (Reset),
		.validData (validData),
		.ack       (ack),
		.lastStep  (lastStep),
		.load      (load),
		.step      (step),
		.done      (done)
	);

	// Shift registers, accumulator and bit counter
	mulDatapath mulDatapath_i
	(
		.Clock    (Clock),
		.Reset    (Reset),
		.a        (a),
		.b        (b),
		.load     (load),
		.step     (step),
		.product  (product),
		.lastStep (lastStep)
	);

endmodule

`default_nettype wire
